//--- hw/tetris_consts.svh
`ifndef TETRIS_CONSTS_SVH
`define TETRIS_CONSTS_SVH

`define GAME_WIDTH 10
`define GAME_HEIGHT 20
`define CELL_ADDR_W 12
`define NUM_PIECES 7
`define PIECE_BLOCKS 4

// Worst-case cycle counts from the accepting strobe
`define LOCK_CYCLES_MAX 720
`define MOVE_CYCLES_MAX 12
`define WIPE_CYCLES_MAX 210

`endif

//--- hw/tetris_pkg.sv
`include "tetris_consts.svh"

package tetris_pkg;

    typedef logic [2:0] piece_t;                    // 0 empty, 1..7 Z T S O L J I
    typedef logic signed [5:0] col_t;
    typedef logic signed [6:0] row_t;
    typedef logic [`CELL_ADDR_W-1:0] cell_addr_t;   // Row * width + column

    typedef col_t [`PIECE_BLOCKS-1:0] block_cols_t;
    typedef row_t [`PIECE_BLOCKS-1:0] block_rows_t;

    typedef enum logic [1:0] {ACT_FALL, ACT_MOVE, ACT_ROT} action_t;

    typedef enum logic [3:0] {
        ST_WIPE, ST_SPAWN, ST_READY,
        ST_CHECK_FALL, ST_APPLY_FALL,
        ST_CHECK_MOVE, ST_APPLY_MOVE,
        ST_CHECK_ROT, ST_APPLY_ROT,
        ST_WRITE_PIECE, ST_SCAN, ST_OVER
    } ctrl_state_t;

endpackage

//--- hw/playfield_store.sv
`timescale 1ns/1ps
`include "tetris_consts.svh"

module playfield_store (
    input  logic                                            clk,
    input  tetris_pkg::cell_addr_t                          display_query_pos,
    input  tetris_pkg::cell_addr_t                          board_addr,
    input  logic                                            board_we,
    input  tetris_pkg::piece_t                              board_wdata,
    output tetris_pkg::piece_t                              board_rdata,
    input  tetris_pkg::cell_addr_t [`PIECE_BLOCKS-1:0]      piece_cells,
    input  tetris_pkg::piece_t                              current_piece,
    output tetris_pkg::piece_t                              display_query_res
);

    tetris_pkg::piece_t     mem [0:(1 << `CELL_ADDR_W) - 1];    // Board uses the low 200
    tetris_pkg::piece_t     disp_rdata;
    tetris_pkg::cell_addr_t query_q;

    always_ff @(posedge clk) begin
        if (board_we)
            mem[board_addr] <= board_wdata;
        board_rdata <= mem[board_addr];
        disp_rdata  <= mem[display_query_pos];
        query_q     <= display_query_pos;       // Aligns with read data
    end

    // Falling piece wins over the stored cell
    assign display_query_res = (query_q == piece_cells[0] || query_q == piece_cells[1] ||
                                query_q == piece_cells[2] || query_q == piece_cells[3])
                               ? current_piece : disp_rdata;

    a_write_in_board: assert property (@(posedge clk)
        board_we |-> board_addr < `GAME_WIDTH * `GAME_HEIGHT);

endmodule

//--- hw/piece_spawner.sv
`timescale 1ns/1ps
`include "tetris_consts.svh"

module piece_spawner (
    input  logic                    clk,
    input  logic                    reset_game,
    input  logic                    spawn,
    output tetris_pkg::piece_t      next_piece,
    output tetris_pkg::block_cols_t spawn_cols,
    output tetris_pkg::block_rows_t spawn_rows
);

    always_ff @(posedge clk) begin
        if (reset_game)
            next_piece <= 3'd1;
        else if (spawn)
            next_piece <= (next_piece == `NUM_PIECES) ? 3'd1 : next_piece + 3'd1;
    end

    // Block 3 comes first in each list as the rotation pivot
    always_comb begin
        case (next_piece)
            3'd2: begin     // T
                spawn_cols = {6'sd7, 6'sd6, 6'sd5, 6'sd6};
                spawn_rows = {7'sd18, 7'sd18, 7'sd18, 7'sd19};
            end
            3'd3: begin     // S
                spawn_cols = {6'sd6, 6'sd5, 6'sd7, 6'sd6};
                spawn_rows = {7'sd18, 7'sd18, 7'sd19, 7'sd19};
            end
            3'd4: begin     // O
                spawn_cols = {6'sd7, 6'sd6, 6'sd7, 6'sd6};
                spawn_rows = {7'sd18, 7'sd18, 7'sd19, 7'sd19};
            end
            3'd5: begin     // L
                spawn_cols = {6'sd7, 6'sd6, 6'sd5, 6'sd7};
                spawn_rows = {7'sd18, 7'sd18, 7'sd18, 7'sd19};
            end
            3'd6: begin     // J
                spawn_cols = {6'sd7, 6'sd6, 6'sd5, 6'sd5};
                spawn_rows = {7'sd18, 7'sd18, 7'sd18, 7'sd19};
            end
            3'd7: begin     // I
                spawn_cols = {6'sd8, 6'sd7, 6'sd6, 6'sd5};
                spawn_rows = {7'sd18, 7'sd18, 7'sd18, 7'sd18};
            end
            default: begin  // Z
                spawn_cols = {6'sd7, 6'sd6, 6'sd6, 6'sd5};
                spawn_rows = {7'sd18, 7'sd18, 7'sd19, 7'sd19};
            end
        endcase
    end

    // A second spawn in a row would skip a piece
    a_spawn_single: assert property (@(posedge clk) disable iff (reset_game)
        spawn |=> !spawn);

endmodule

//--- hw/piece_geometry.sv
`timescale 1ns/1ps
`include "tetris_consts.svh"

module piece_geometry (
    input  tetris_pkg::block_cols_t                         cur_cols,
    input  tetris_pkg::block_rows_t                         cur_rows,
    input  tetris_pkg::action_t                             action,
    input  logic                                            dir_right,
    output tetris_pkg::block_cols_t                         cand_cols,
    output tetris_pkg::block_rows_t                         cand_rows,
    output tetris_pkg::cell_addr_t [`PIECE_BLOCKS-1:0]      cand_addr,
    output logic [`PIECE_BLOCKS-1:0]                        cand_oob,
    output tetris_pkg::cell_addr_t [`PIECE_BLOCKS-1:0]      piece_cells
);

    always_comb begin
        tetris_pkg::col_t pc, c, dc, nc;
        tetris_pkg::row_t pr, r, dr, nr;
        pc = cur_cols[3];
        pr = cur_rows[3];
        for (int i = 0; i < `PIECE_BLOCKS; i++) begin
            c  = cur_cols[i];
            r  = cur_rows[i];
            dc = c - pc;
            dr = r - pr;
            case (action)
                tetris_pkg::ACT_FALL: begin
                    nc = c;
                    nr = r - 7'sd1;
                end
                tetris_pkg::ACT_MOVE: begin
                    nc = dir_right ? c + 6'sd1 : c - 6'sd1;
                    nr = r;
                end
                default: begin          // Quarter turn about block 3
                    nc = dir_right ? tetris_pkg::col_t'(pc + dr) : tetris_pkg::col_t'(pc - dr);
                    nr = dir_right ? tetris_pkg::row_t'(pr - dc) : tetris_pkg::row_t'(pr + dc);
                end
            endcase
            cand_cols[i]   = nc;
            cand_rows[i]   = nr;
            cand_oob[i]    = nc < 0 || nc >= `GAME_WIDTH || nr < 0 || nr >= `GAME_HEIGHT;
            cand_addr[i]   = tetris_pkg::cell_addr_t'(nr * `GAME_WIDTH + nc);
            piece_cells[i] = tetris_pkg::cell_addr_t'(r * `GAME_WIDTH + c);
        end
    end

endmodule

//--- hw/line_scanner.sv
`timescale 1ns/1ps
`include "tetris_consts.svh"

module line_scanner (
    input  logic                        clk,
    input  logic                        reset_game,
    input  logic                        scan_start,
    output logic                        scan_busy,
    output tetris_pkg::cell_addr_t      board_addr,
    output logic                        board_we,
    output tetris_pkg::piece_t          board_wdata,
    input  tetris_pkg::piece_t          board_rdata,
    output logic [`GAME_HEIGHT-1:0]     which_lines_cleared,
    output logic [20:0]                 game_lines_cleared
);

    logic       busy;
    logic       rd_valid;           // board_rdata holds the cell at row, col
    logic       clearing;
    logic [4:0] row;
    logic [3:0] col;
    logic       advance_row;

    assign scan_busy   = busy;
    assign board_addr  = tetris_pkg::cell_addr_t'(row * `GAME_WIDTH + col);
    assign board_we    = busy && clearing;
    assign board_wdata = '0;

    // Row ends on a hole or after the last cleared cell
    assign advance_row = busy && ((clearing && col == `GAME_WIDTH - 1) ||
                                  (!clearing && rd_valid && board_rdata == '0));

    always_ff @(posedge clk) begin
        if (reset_game) begin
            busy                <= 1'b0;
            rd_valid            <= 1'b0;
            clearing            <= 1'b0;
            which_lines_cleared <= '0;
            game_lines_cleared  <= '0;
        end else if (scan_start) begin
            busy                <= 1'b1;
            rd_valid            <= 1'b0;
            clearing            <= 1'b0;
            row                 <= '0;
            col                 <= '0;
            which_lines_cleared <= '0;
        end else if (advance_row) begin
            busy     <= (row != `GAME_HEIGHT - 1);
            row      <= row + 5'd1;
            col      <= '0;
            rd_valid <= 1'b0;
            clearing <= 1'b0;
        end else if (busy) begin
            if (clearing) begin
                col <= col + 4'd1;
            end else if (!rd_valid) begin
                rd_valid <= 1'b1;
            end else if (col == `GAME_WIDTH - 1) begin  // Full row
                which_lines_cleared[row] <= 1'b1;
                game_lines_cleared       <= game_lines_cleared + 21'd1;
                clearing                 <= 1'b1;
                col                      <= '0;
            end else begin
                col      <= col + 4'd1;
                rd_valid <= 1'b0;
            end
        end
    end

    a_no_restart: assert property (@(posedge clk) disable iff (reset_game)
        scan_start |-> !scan_busy);

endmodule

//--- hw/tetris_control.sv
`timescale 1ns/1ps
`include "tetris_consts.svh"

module tetris_control (
    input  logic                                        clk,
    input  logic                                        reset_game,
    input  logic                                        next_fall,
    input  logic                                        move_piece_left,
    input  logic                                        move_piece_right,
    input  logic                                        rotate_left,
    input  logic                                        rotate_right,
    input  tetris_pkg::block_cols_t                     spawn_cols,
    input  tetris_pkg::block_rows_t                     spawn_rows,
    input  tetris_pkg::piece_t                          next_piece,
    output logic                                        spawn,
    input  tetris_pkg::block_cols_t                     cand_cols,
    input  tetris_pkg::block_rows_t                     cand_rows,
    input  tetris_pkg::cell_addr_t [`PIECE_BLOCKS-1:0]  cand_addr,
    input  logic [`PIECE_BLOCKS-1:0]                    cand_oob,
    input  tetris_pkg::cell_addr_t [`PIECE_BLOCKS-1:0]  piece_cells,
    output tetris_pkg::action_t                         action,
    output logic                                        dir_right,
    output tetris_pkg::block_cols_t                     cur_cols,
    output tetris_pkg::block_rows_t                     cur_rows,
    output tetris_pkg::piece_t                          current_piece,
    output tetris_pkg::cell_addr_t                      board_addr,
    output logic                                        board_we,
    output tetris_pkg::piece_t                          board_wdata,
    input  tetris_pkg::piece_t                          board_rdata,
    output logic                                        scan_start,
    input  logic                                        scan_busy,
    input  tetris_pkg::cell_addr_t                      scan_addr,
    input  logic                                        scan_we,
    input  tetris_pkg::piece_t                          scan_wdata,
    output logic                                        game_over
);

    tetris_pkg::ctrl_state_t    state;
    tetris_pkg::cell_addr_t     wipe_addr;
    logic [2:0]                 chk_cnt;    // Block read this cycle, checked next
    logic [1:0]                 prev_idx;
    logic [1:0]                 wr_idx;
    logic                       fresh;      // Not yet fallen since spawn
    logic                       chk_bad;

    assign spawn      = (state == tetris_pkg::ST_SPAWN);
    assign scan_start = (state == tetris_pkg::ST_WRITE_PIECE) && (wr_idx == 2'd3);
    assign prev_idx   = chk_cnt[1:0] - 2'd1;
    assign chk_bad    = (chk_cnt != 3'd0) && (cand_oob[prev_idx] || board_rdata != '0);

    always_comb begin
        board_addr  = cand_addr[chk_cnt[1:0]];
        board_we    = 1'b0;
        board_wdata = current_piece;
        case (state)
            tetris_pkg::ST_WIPE: begin
                board_addr  = wipe_addr;
                board_we    = 1'b1;
                board_wdata = '0;
            end
            tetris_pkg::ST_WRITE_PIECE: begin
                board_addr = piece_cells[wr_idx];
                board_we   = 1'b1;
            end
            tetris_pkg::ST_SCAN: begin      // Scanner owns port B
                board_addr  = scan_addr;
                board_we    = scan_we;
                board_wdata = scan_wdata;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_game) begin
            state         <= tetris_pkg::ST_WIPE;
            wipe_addr     <= '0;
            chk_cnt       <= '0;
            wr_idx        <= '0;
            fresh         <= 1'b0;
            action        <= tetris_pkg::ACT_FALL;
            dir_right     <= 1'b0;
            current_piece <= '0;
            game_over     <= 1'b0;
        end else begin
            case (state)
                tetris_pkg::ST_WIPE: begin
                    wipe_addr <= wipe_addr + 1'b1;
                    if (wipe_addr == `GAME_WIDTH * `GAME_HEIGHT - 1)
                        state <= tetris_pkg::ST_SPAWN;
                end
                tetris_pkg::ST_SPAWN: begin
                    cur_cols      <= spawn_cols;
                    cur_rows      <= spawn_rows;
                    current_piece <= next_piece;
                    fresh         <= 1'b1;
                    state         <= tetris_pkg::ST_READY;
                end
                tetris_pkg::ST_READY: begin
                    chk_cnt <= '0;
                    if (next_fall) begin
                        action <= tetris_pkg::ACT_FALL;
                        state  <= tetris_pkg::ST_CHECK_FALL;
                    end else if (move_piece_left || move_piece_right) begin
                        action    <= tetris_pkg::ACT_MOVE;
                        dir_right <= move_piece_right;
                        state     <= tetris_pkg::ST_CHECK_MOVE;
                    end else if (rotate_left || rotate_right) begin
                        action    <= tetris_pkg::ACT_ROT;
                        dir_right <= rotate_right;
                        state     <= tetris_pkg::ST_CHECK_ROT;
                    end
                end
                tetris_pkg::ST_CHECK_FALL, tetris_pkg::ST_CHECK_MOVE,
                tetris_pkg::ST_CHECK_ROT: begin
                    chk_cnt <= chk_cnt + 3'd1;
                    if (chk_bad) begin
                        if (state != tetris_pkg::ST_CHECK_FALL) begin
                            state <= tetris_pkg::ST_READY;
                        end else if (fresh) begin
                            state     <= tetris_pkg::ST_OVER;
                            game_over <= 1'b1;
                        end else begin
                            state  <= tetris_pkg::ST_WRITE_PIECE;   // Lock in place
                            wr_idx <= '0;
                        end
                    end else if (chk_cnt == 3'd4) begin
                        case (state)
                            tetris_pkg::ST_CHECK_FALL: state <= tetris_pkg::ST_APPLY_FALL;
                            tetris_pkg::ST_CHECK_MOVE: state <= tetris_pkg::ST_APPLY_MOVE;
                            default:                   state <= tetris_pkg::ST_APPLY_ROT;
                        endcase
                    end
                end
                tetris_pkg::ST_APPLY_FALL, tetris_pkg::ST_APPLY_MOVE,
                tetris_pkg::ST_APPLY_ROT: begin
                    cur_cols <= cand_cols;
                    cur_rows <= cand_rows;
                    if (state == tetris_pkg::ST_APPLY_FALL)
                        fresh <= 1'b0;
                    state <= tetris_pkg::ST_READY;
                end
                tetris_pkg::ST_WRITE_PIECE: begin
                    wr_idx <= wr_idx + 2'd1;
                    if (wr_idx == 2'd3)
                        state <= tetris_pkg::ST_SCAN;
                end
                tetris_pkg::ST_SCAN: begin
                    if (!scan_busy)
                        state <= tetris_pkg::ST_SPAWN;
                end
                default: ;  // Over holds until reset
            endcase
        end
    end

    // Row wipes from the scanner only land while port B is handed over
    a_scan_write_owned: assert property (@(posedge clk) disable iff (reset_game)
        scan_we |-> state == tetris_pkg::ST_SCAN);

endmodule

//--- hw/tetris_engine.sv
`timescale 1ns/1ps
`include "tetris_consts.svh"

module tetris_engine (
    input  logic                        clk,
    input  logic                        reset_game,
    input  logic                        next_fall,
    input  logic                        move_piece_right,
    input  logic                        move_piece_left,
    input  logic                        rotate_right,
    input  logic                        rotate_left,
    input  tetris_pkg::cell_addr_t      display_query_pos,
    output tetris_pkg::piece_t          next_piece,
    output tetris_pkg::piece_t          display_query_res,
    output logic                        game_over,
    output logic [`GAME_HEIGHT-1:0]     which_lines_cleared,
    output logic [20:0]                 game_lines_cleared
);

    tetris_pkg::block_cols_t                    cur_cols, cand_cols, spawn_cols;
    tetris_pkg::block_rows_t                    cur_rows, cand_rows, spawn_rows;
    tetris_pkg::cell_addr_t [`PIECE_BLOCKS-1:0] cand_addr, piece_cells;
    logic [`PIECE_BLOCKS-1:0]                   cand_oob;
    tetris_pkg::action_t                        action;
    logic                                       dir_right, spawn;
    tetris_pkg::piece_t                         current_piece;
    tetris_pkg::cell_addr_t                     board_addr, scan_addr;
    logic                                       board_we, scan_we;
    tetris_pkg::piece_t                         board_wdata, board_rdata, scan_wdata;
    logic                                       scan_start, scan_busy;

    tetris_control u_control (
        .clk, .reset_game, .next_fall,
        .move_piece_left, .move_piece_right, .rotate_left, .rotate_right,
        .spawn_cols, .spawn_rows, .next_piece, .spawn,
        .cand_cols, .cand_rows, .cand_addr, .cand_oob, .piece_cells,
        .action, .dir_right, .cur_cols, .cur_rows, .current_piece,
        .board_addr, .board_we, .board_wdata, .board_rdata,
        .scan_start, .scan_busy, .scan_addr, .scan_we, .scan_wdata,
        .game_over
    );

    piece_geometry u_geometry (
        .cur_cols, .cur_rows, .action, .dir_right,
        .cand_cols, .cand_rows, .cand_addr, .cand_oob, .piece_cells
    );

    piece_spawner u_spawner (
        .clk, .reset_game, .spawn, .next_piece, .spawn_cols, .spawn_rows
    );

    line_scanner u_scanner (
        .clk, .reset_game, .scan_start, .scan_busy,
        .board_addr  (scan_addr),
        .board_we    (scan_we),
        .board_wdata (scan_wdata),
        .board_rdata,
        .which_lines_cleared, .game_lines_cleared
    );

    playfield_store u_store (
        .clk, .display_query_pos,
        .board_addr, .board_we, .board_wdata, .board_rdata,
        .piece_cells, .current_piece, .display_query_res
    );

endmodule

//--- verif/tetris_engine_tb.sv
`timescale 1ns/1ps
`include "tetris_consts.svh"

module tetris_engine_tb;

    localparam int CELLS       = `GAME_WIDTH * `GAME_HEIGHT;
    localparam int SNAP_CYCLES = CELLS + 1;
    localparam int FALL_STEP   = 2 + `LOCK_CYCLES_MAX + SNAP_CYCLES;
    localparam int MOVE_STEP   = 2 + `MOVE_CYCLES_MAX + 4 + SNAP_CYCLES;
    localparam int WATCHDOG_CYCLES = 700 * (FALL_STEP + 2 * MOVE_STEP)
                                   + 4 * (`WIPE_CYCLES_MAX + 10 + SNAP_CYCLES) + 12 * MOVE_STEP;

    // Spawn cells of Z T S O L J I, pivot block first
    localparam int SPAWN_COL [7][4] = '{'{7, 6, 6, 5}, '{7, 6, 5, 6}, '{6, 5, 7, 6},
                                        '{7, 6, 7, 6}, '{7, 6, 5, 7}, '{7, 6, 5, 5},
                                        '{8, 7, 6, 5}};
    localparam int SPAWN_ROW [7][4] = '{'{18, 18, 19, 19}, '{18, 18, 18, 19},
                                        '{18, 18, 19, 19}, '{18, 18, 19, 19},
                                        '{18, 18, 18, 19}, '{18, 18, 18, 19},
                                        '{18, 18, 18, 18}};

    logic                       clk = 1'b0;
    logic                       reset_game;
    logic                       next_fall;
    logic                       move_piece_right;
    logic                       move_piece_left;
    logic                       rotate_right;
    logic                       rotate_left;
    tetris_pkg::cell_addr_t     display_query_pos;
    tetris_pkg::piece_t         next_piece;
    tetris_pkg::piece_t         display_query_res;
    logic                       game_over;
    logic [`GAME_HEIGHT-1:0]    which_lines_cleared;
    logic [20:0]                game_lines_cleared;

    int          board [CELLS];     // Locked cells only
    int          snap [CELLS];
    int          pcol [4];
    int          prow [4];
    int          piece;
    int          nxt;
    int          lines;
    int          flags;
    bit          fresh;
    bit          over;
    logic [31:0] rng;

    tetris_engine dut0 (
        .clk, .reset_game, .next_fall, .move_piece_right, .move_piece_left,
        .rotate_right, .rotate_left, .display_query_pos, .next_piece,
        .display_query_res, .game_over, .which_lines_cleared, .game_lines_cleared
    );

    always #4 clk = ~clk;

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Errors found");
        $fatal(1, "Watchdog expired before both games reached game over");
    end

    task automatic report_mismatch(input string name, input int got, input int expected);
        $display("** Error at %0t: %s is %0d, expected %0d", $time, name, got, expected);
        $display("Errors found");
        $fatal(1, "Mismatch on %s", name);
    endtask

    a_over_sticky: assert property (@(posedge clk) disable iff (reset_game)
        game_over |=> game_over) else report_mismatch("game_over", int'(game_over), 1);

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic int shown_cell(input int a);
        for (int b = 0; b < 4; b++)
            if (prow[b] * `GAME_WIDTH + pcol[b] == a)
                return piece;
        return board[a];
    endfunction

    task automatic load_spawn(input int id);
        piece = id;
        nxt   = (id == `NUM_PIECES) ? 1 : id + 1;
        fresh = 1'b1;
        for (int b = 0; b < 4; b++) begin
            pcol[b] = SPAWN_COL[id-1][b];
            prow[b] = SPAWN_ROW[id-1][b];
        end
    endtask

    // Pipelined read, result trails the position by one cycle
    task automatic take_snapshot();
        for (int i = 0; i <= CELLS; i++) begin
            @(negedge clk);
            if (i > 0)
                snap[i-1] = int'(display_query_res);
            if (i < CELLS)
                display_query_pos = tetris_pkg::cell_addr_t'(i);
        end
    endtask

    task automatic check_state();
        take_snapshot();
        for (int i = 0; i < CELLS; i++)
            assert (snap[i] == shown_cell(i)) else
                report_mismatch($sformatf("display_query_res[%0d]", i), snap[i], shown_cell(i));
        assert (int'(next_piece) == nxt) else report_mismatch("next_piece", int'(next_piece), nxt);
        assert (game_over == over) else report_mismatch("game_over", int'(game_over), int'(over));
        assert (int'(which_lines_cleared) == flags) else
            report_mismatch("which_lines_cleared", int'(which_lines_cleared), flags);
        assert (int'(game_lines_cleared) == lines) else
            report_mismatch("game_lines_cleared", int'(game_lines_cleared), lines);
    endtask

    task automatic pulse_strobe(input int kind);
        @(negedge clk);
        case (kind)
            0: next_fall = 1'b1;
            1: move_piece_left = 1'b1;
            2: move_piece_right = 1'b1;
            3: rotate_left = 1'b1;
            default: rotate_right = 1'b1;
        endcase
        @(negedge clk);
        {next_fall, move_piece_left, move_piece_right, rotate_left, rotate_right} = 5'b0;
    endtask

    // Full rows come from the pre-fall snapshot, which shows the piece where it locks
    task automatic lock_piece();
        bit full;
        flags = 0;
        for (int b = 0; b < 4; b++)
            board[prow[b] * `GAME_WIDTH + pcol[b]] = piece;
        for (int r = 0; r < `GAME_HEIGHT; r++) begin
            full = 1'b1;
            for (int c = 0; c < `GAME_WIDTH; c++)
                if (snap[r * `GAME_WIDTH + c] == 0)
                    full = 1'b0;
            if (full) begin
                flags = flags | (1 << r);
                lines = lines + 1;
                for (int c = 0; c < `GAME_WIDTH; c++)
                    board[r * `GAME_WIDTH + c] = 0;     // Emptied in place
            end
        end
        load_spawn(nxt);
    endtask

    // Kind 0 fall, 1 left, 2 right, 3 rotate left, 4 rotate right
    task automatic do_step(input int kind);
        int nc [4];
        int nr [4];
        bit blocked;
        blocked = 1'b0;
        for (int b = 0; b < 4; b++) begin
            nc[b] = pcol[b];
            nr[b] = prow[b];
            case (kind)
                0: nr[b] = prow[b] - 1;
                1: nc[b] = pcol[b] - 1;
                2: nc[b] = pcol[b] + 1;
                3: begin
                    nc[b] = pcol[0] - (prow[b] - prow[0]);
                    nr[b] = prow[0] + (pcol[b] - pcol[0]);
                end
                default: begin
                    nc[b] = pcol[0] + (prow[b] - prow[0]);
                    nr[b] = prow[0] - (pcol[b] - pcol[0]);
                end
            endcase
            if (nc[b] < 0 || nc[b] >= `GAME_WIDTH || nr[b] < 0 || nr[b] >= `GAME_HEIGHT)
                blocked = 1'b1;
            else if (board[nr[b] * `GAME_WIDTH + nc[b]] != 0)
                blocked = 1'b1;
        end
        pulse_strobe(kind);
        repeat ((kind == 0) ? `LOCK_CYCLES_MAX : `MOVE_CYCLES_MAX + 4) @(negedge clk);
        if (!blocked) begin
            pcol = nc;
            prow = nr;
            if (kind == 0)
                fresh = 1'b0;
        end else if (kind == 0 && fresh) begin
            over = 1'b1;                        // First fall of a new piece blocked
        end else if (kind == 0) begin
            lock_piece();
        end
        check_state();
    endtask

    task automatic start_game();
        reset_game = 1'b1;
        repeat (10) @(negedge clk);
        reset_game = 1'b0;
        foreach (board[i])
            board[i] = 0;
        lines = 0;
        flags = 0;
        over  = 1'b0;
        load_spawn(1);
        repeat (`WIPE_CYCLES_MAX) @(negedge clk);
        check_state();
    endtask

    initial begin
        int kind;
        reset_game        = 1'b1;
        next_fall         = 1'b0;
        move_piece_right  = 1'b0;
        move_piece_left   = 1'b0;
        rotate_right      = 1'b0;
        rotate_left       = 1'b0;
        display_query_pos = '0;
        rng               = 32'hfc1f_2a71;
        for (int g = 0; g < 2; g++) begin
            start_game();
            while (!over) begin
                rng = xorshift32(rng);
                case (rng[1:0])
                    2'd0, 2'd1: kind = 0;
                    2'd2:       kind = 1 + int'(rng[2]);
                    default:    kind = 3 + int'(rng[2]);
                endcase
                do_step(kind);
            end
            repeat (6) begin                    // Over ignores every strobe
                rng = xorshift32(rng);
                pulse_strobe(int'(rng[5:3]) % 5);
                repeat (`MOVE_CYCLES_MAX + 4) @(negedge clk);
                check_state();
            end
        end
        $display("No errors");
        $finish;
    end

endmodule

//--- list.f
+incdir+hw
hw/tetris_pkg.sv
hw/playfield_store.sv
hw/piece_spawner.sv
hw/piece_geometry.sv
hw/line_scanner.sv
hw/tetris_control.sv
hw/tetris_engine.sv
verif/tetris_engine_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -f list.f --top-module tetris_engine_tb -o tetris_sim \
    && ./obj_dir/tetris_sim \
    || exit 1
